// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= aqr_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, pass on TEST OK"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+.
aqr_pkg.sv
tape_clock.sv
mem_arbiter.sv
mem_ram.sv
tape_player.sv
aqr_mem_core.sv
aqr_props.sv
aqr_tb.sv

// ==== aqr_macros.svh ====
`default_nettype none

`ifndef AQR_MACROS_SVH
`define AQR_MACROS_SVH

////////////////////////////////
// Memory map
////////////////////////////////

// 128 KB shared byte memory
`define MEM_AW 17

`define MAINROM_BASE 17'h00000
`define EXTROM_BASE 17'h0C000
`define TAPE_BASE 17'h10000

////////////////////////////////
// Tape bit rate
////////////////////////////////

// clk_sys cycles per tape bit, shortened for simulation
`define TAPE_DIV 40
`define TAPE_DIV_FAST 8

`endif

`default_nettype wire

// ==== aqr_mem_core.sv ====
`default_nettype none

module aqr_mem_core import aqr_pkg::*; (
    input  wire            clk_sys,
    input  wire            cpu_reset,
    input  wire            fast_tape,
    input  wire ioctl_t    ioctl,
    input  wire cpu_bus_t  cpu,
    output logic [7:0]     cpu_rdata,
    output logic           cpu_ready,
    output logic           cpu_hold,
    output logic           rom_loaded,
    output logic           cass_out,
    output logic           tape_playing
);

    logic        ce_tape;
    mem_req_t    mem_req;
    logic [7:0]  mem_rdata;
    logic        mem_ready;
    logic        tape_req;
    logic [15:0] tape_addr;
    logic        tape_ready;

    // CPU and tape share the one read port
    assign cpu_rdata = mem_rdata;

    ////////////////////////////////
    // Tape rate
    ////////////////////////////////

    tape_clock u_tape_clock (
        .clk_sys   (clk_sys),
        .cpu_reset (cpu_reset),
        .fast_tape (fast_tape),
        .ce_tape   (ce_tape)
    );

    ////////////////////////////////
    // Shared memory
    ////////////////////////////////

    mem_arbiter u_mem_arbiter (
        .clk_sys    (clk_sys),
        .cpu_reset  (cpu_reset),
        .ioctl      (ioctl),
        .cpu        (cpu),
        .tape_req   (tape_req),
        .tape_addr  (tape_addr),
        .mem_ready  (mem_ready),
        .mem_req    (mem_req),
        .cpu_ready  (cpu_ready),
        .tape_ready (tape_ready),
        .cpu_hold   (cpu_hold),
        .rom_loaded (rom_loaded)
    );

    mem_ram u_mem_ram (
        .clk_sys   (clk_sys),
        .cpu_reset (cpu_reset),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    ////////////////////////////////
    // Cassette output
    ////////////////////////////////

    tape_player u_tape_player (
        .clk_sys      (clk_sys),
        .cpu_reset    (cpu_reset),
        .ce_tape      (ce_tape),
        .ioctl        (ioctl),
        .tape_ready   (tape_ready),
        .mem_rdata    (mem_rdata),
        .tape_req     (tape_req),
        .tape_addr    (tape_addr),
        .cass_out     (cass_out),
        .tape_playing (tape_playing)
    );

endmodule

`default_nettype wire

// ==== aqr_pkg.sv ====
`include "aqr_macros.svh"

`default_nettype none

package aqr_pkg;

    // Loader stream from the download transport
    typedef struct packed {
        logic        download;
        logic [1:0]  index;
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  dout;
    } ioctl_t;

    // One request into the shared memory
    typedef struct packed {
        logic [`MEM_AW-1:0] addr;
        logic               rd;
        logic               we;
        logic [7:0]         wdata;
    } mem_req_t;

    // CPU side access, held until cpu_ready
    typedef struct packed {
        logic [15:0] addr;
        logic        rd;
        logic        wr;
        logic [7:0]  wdata;
    } cpu_bus_t;

    // Which user owns the request in flight
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_LOADER,
        SRC_CPU,
        SRC_TAPE
    } mem_src_t;

endpackage

`default_nettype wire

// ==== aqr_props.sv ====
`default_nettype none

module aqr_props (
    input wire clk_sys,
    input wire cpu_reset,
    input wire cpu_ready,
    input wire tape_ready,
    input wire tape_req,
    input wire ce_tape,
    input wire cass_out,
    input wire tape_playing
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions
    int fail_count = 0;

    // Ready belongs to one requester only
    ready_one_owner: assert property (@(posedge clk_sys) disable iff (cpu_reset)
        !(cpu_ready && tape_ready))
        else begin
            fail_count++;
            $error("cpu_ready and tape_ready high in the same cycle");
        end

    tape_req_held: assert property (@(posedge clk_sys) disable iff (cpu_reset)
        (tape_req && !tape_ready) |=> tape_req)
        else begin
            fail_count++;
            $error("tape_req dropped before tape_ready");
        end

    // Bit edges only on the tape strobe while playing
    cass_on_strobe: assert property (@(posedge clk_sys) disable iff (cpu_reset)
        (tape_playing && !ce_tape) |=> $stable(cass_out))
        else begin
            fail_count++;
            $error("cass_out changed without ce_tape");
        end

endmodule

bind aqr_mem_core aqr_props u_props (
    .clk_sys      (clk_sys),
    .cpu_reset    (cpu_reset),
    .cpu_ready    (cpu_ready),
    .tape_ready   (tape_ready),
    .tape_req     (tape_req),
    .ce_tape      (ce_tape),
    .cass_out     (cass_out),
    .tape_playing (tape_playing)
);

`default_nettype wire

// ==== aqr_tb.sv ====
`include "aqr_macros.svh"

`default_nettype none

module aqr_tb import aqr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 100;
    localparam int IN_DELAY = 10;
    localparam int MAIN_LEN = 256;
    localparam int EXT_LEN = 256;
    localparam int N_READS = 24;
    localparam int N_ACC = 32;
    localparam int BURST_LEN = 12;
    localparam int TAPE_MAX = 12;
    localparam int ACC_LIMIT = 64;

    // Rough cycle count of each test
    localparam int T_ROM = MAIN_LEN + EXT_LEN + 4 * N_READS + 16;
    localparam int T_CPU = 8 * N_ACC;
    localparam int T_PRIO = BURST_LEN + 16;
    localparam int T_TAPE = TAPE_MAX + 16 + (8 * TAPE_MAX + 3) * `TAPE_DIV;
    localparam int T_FAST = TAPE_MAX + 16 + (8 * TAPE_MAX + 3) * `TAPE_DIV_FAST + 3 * `TAPE_DIV;
    localparam int T_TOTAL = 8 + T_ROM + T_CPU + T_PRIO + T_TAPE + T_FAST;

    logic       clk_sys;
    logic       cpu_reset;
    logic       fast_tape;
    ioctl_t     ioctl;
    cpu_bus_t   cpu;
    logic [7:0] cpu_rdata;
    logic       cpu_ready;
    logic       cpu_hold;
    logic       rom_loaded;
    logic       cass_out;
    logic       tape_playing;

    // Expected contents of the shared memory
    logic [7:0] model [0:(1 << `MEM_AW) - 1];

    integer seed;
    int     checks;
    int     errors;
    int     test_num;
    int     test_errors;
    string  test_name;

    aqr_mem_core uut (
        .clk_sys      (clk_sys),
        .cpu_reset    (cpu_reset),
        .fast_tape    (fast_tape),
        .ioctl        (ioctl),
        .cpu          (cpu),
        .cpu_rdata    (cpu_rdata),
        .cpu_ready    (cpu_ready),
        .cpu_hold     (cpu_hold),
        .rom_loaded   (rom_loaded),
        .cass_out     (cass_out),
        .tape_playing (tape_playing)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    initial begin
        #(2 * T_TOTAL * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", 2 * T_TOTAL);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////
    // Helpers
    ////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #(IN_DELAY);
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("test %0d %s: %s, %0d errors", test_num, test_name,
                 (errors == test_errors) ? "passed" : "failed", errors - test_errors);
    endtask

    // Region map of the loader
    function automatic logic [`MEM_AW-1:0] loader_target(input logic [1:0] idx,
                                                         input logic [15:0] addr);
        case (idx)
            2'd0:    return `MAINROM_BASE + `MEM_AW'(addr[12:0]);
            2'd1:    return `EXTROM_BASE + `MEM_AW'(addr[13:0]);
            default: return `TAPE_BASE + `MEM_AW'(addr);
        endcase
    endfunction

    // One write per cycle with random upper address bits where the region ignores them
    task automatic loader_burst(input logic [1:0] idx, input int len);
        logic [15:0] a;
        logic [7:0]  d;
        int          i;
        for (i = 0; i < len; i++) begin
            a = 16'($random(seed));
            d = 8'($random(seed));
            case (idx)
                2'd0:    a[12:0] = 13'(i);
                2'd1:    a[13:0] = 14'(i);
                default: a = 16'(i);
            endcase
            ioctl.wr   = 1'b1;
            ioctl.addr = a;
            ioctl.dout = d;
            model[loader_target(idx, a)] = d;
            @(negedge clk_sys);
            check_value("cpu_hold", 32'(idx != 2'd1), 32'(cpu_hold));
            next_cycle();
        end
        ioctl.wr = 1'b0;
    endtask

    task automatic load_image(input logic [1:0] idx, input int len);
        ioctl.download = 1'b1;
        ioctl.index    = idx;
        next_cycle();
        loader_burst(idx, len);
        next_cycle();
        ioctl.download = 1'b0;
        @(negedge clk_sys);
        check_value("cpu_hold", 32'd0, 32'(cpu_hold));
        next_cycle();
    endtask

    // Request held until cpu_ready and cycles counts the clock edges up to it
    task automatic cpu_access(input logic wr, input logic [15:0] addr, input logic [7:0] wdata,
                              output logic [7:0] rdata, output int cycles);
        cpu.addr  = addr;
        cpu.rd    = !wr;
        cpu.wr    = wr;
        cpu.wdata = wdata;
        cycles    = 0;
        rdata     = 8'hxx;
        do begin
            @(posedge clk_sys);
            cycles++;
            @(negedge clk_sys);
        end while (!cpu_ready && cycles < ACC_LIMIT);
        if (cpu_ready) begin
            rdata = cpu_rdata;
            if (wr) begin
                model[`MEM_AW'(addr)] = wdata;
            end
        end else begin
            report_failure($sformatf("CPU access at %h never got cpu_ready", addr));
        end
        next_cycle();
        cpu.rd = 1'b0;
        cpu.wr = 1'b0;
    endtask

    task automatic read_and_compare(input logic [15:0] addr);
        logic [7:0] rd;
        int         cyc;
        cpu_access(1'b0, addr, 8'h00, rd, cyc);
        check_value("cpu_rdata", 32'(model[`MEM_AW'(addr)]), 32'(rd));
    endtask

    // Sample cass_out mid window from the rise of tape_playing
    task automatic play_tape(input int div, input int len);
        logic [`MEM_AW-1:0] ma;
        logic [2:0]         bsel;
        int                 waited;
        int                 k;
        waited = 0;
        do begin
            @(negedge clk_sys);
            waited++;
        end while (!tape_playing && waited < 3 * div + 16);
        if (!tape_playing) begin
            report_failure("tape playback never started");
            return;
        end
        repeat (div / 2) @(negedge clk_sys);
        for (k = 0; k < 8 * len; k++) begin
            ma   = `TAPE_BASE + `MEM_AW'(k / 8);
            bsel = 3'(7 - k % 8);
            check_value("tape_playing", 32'd1, 32'(tape_playing));
            check_value("cass_out", 32'(model[ma][bsel]), 32'(cass_out));
            repeat (div) @(negedge clk_sys);
        end
        check_value("tape_playing", 32'd0, 32'(tape_playing));
        check_value("cass_out", 32'd0, 32'(cass_out));
        next_cycle();
    endtask

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////

    initial begin
        logic [7:0]  rdata;
        logic [7:0]  wdata;
        logic [15:0] addr;
        logic [15:0] wr_addrs [$];
        int          cycles;
        int          len;
        int          i;
        seed        = 32'h66ca;
        checks      = 0;
        errors      = 0;
        test_num    = 0;
        test_errors = 0;
        cpu_reset   = 1'b1;
        fast_tape   = 1'b0;
        ioctl       = '0;
        cpu         = '0;

        begin_test("reset");
        repeat (4) @(posedge clk_sys);
        #(IN_DELAY);
        cpu_reset = 1'b0;
        @(negedge clk_sys);
        check_value("cpu_ready", 32'd0, 32'(cpu_ready));
        check_value("tape_playing", 32'd0, 32'(tape_playing));
        check_value("cass_out", 32'd0, 32'(cass_out));
        check_value("rom_loaded", 32'd0, 32'(rom_loaded));
        next_cycle();
        end_test();

        begin_test("rom loads");
        load_image(2'd0, MAIN_LEN);
        check_value("rom_loaded", 32'd0, 32'(rom_loaded));
        load_image(2'd1, EXT_LEN);
        check_value("rom_loaded", 32'd1, 32'(rom_loaded));
        for (i = 0; i < N_READS; i++) begin
            if (i % 2 == 0) begin
                addr = 16'(`MAINROM_BASE) + 16'($unsigned($random(seed)) % MAIN_LEN);
            end else begin
                addr = 16'(`EXTROM_BASE) + 16'($unsigned($random(seed)) % EXT_LEN);
            end
            read_and_compare(addr);
        end
        end_test();

        begin_test("cpu write and readback");
        for (i = 0; i < N_ACC; i++) begin
            addr  = 16'($random(seed));
            wdata = 8'($random(seed));
            cpu_access(1'b1, addr, wdata, rdata, cycles);
            wr_addrs.push_back(addr);
        end
        while (wr_addrs.size() > 0) begin
            read_and_compare(wr_addrs.pop_front());
        end
        end_test();

        // CPU read lands behind a burst of extension ROM writes
        begin_test("loader priority");
        ioctl.download = 1'b1;
        ioctl.index    = 2'd1;
        next_cycle();
        addr = 16'(`MAINROM_BASE) + 16'($unsigned($random(seed)) % MAIN_LEN);
        fork
            loader_burst(2'd1, BURST_LEN);
            cpu_access(1'b0, addr, 8'h00, rdata, cycles);
        join
        check_value("cpu_rdata", 32'(model[`MEM_AW'(addr)]), 32'(rdata));
        check_value("cpu_latency", 32'(BURST_LEN + 1), 32'(cycles));
        ioctl.download = 1'b0;
        next_cycle();
        end_test();

        begin_test("tape normal");
        len = 6 + int'($unsigned($random(seed)) % 7);
        load_image(2'd2, len);
        play_tape(`TAPE_DIV, len);
        end_test();

        begin_test("tape fast");
        fast_tape = 1'b1;
        // Divider picks up the mode at its next wrap
        repeat (`TAPE_DIV + 2) next_cycle();
        len = 6 + int'($unsigned($random(seed)) % 7);
        load_image(2'd2, len);
        play_tape(`TAPE_DIV_FAST, len);
        end_test();

        if (uut.u_props.fail_count != 0) begin
            report_failure($sformatf("%0d assertion failures in the bound checker",
                                     uut.u_props.fail_count));
        end

        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`include "aqr_macros.svh"

`default_nettype none

module mem_arbiter import aqr_pkg::*; (
    input  wire            clk_sys,
    input  wire            cpu_reset,
    input  wire ioctl_t    ioctl,
    input  wire cpu_bus_t  cpu,
    input  wire            tape_req,
    input  wire [15:0]     tape_addr,
    input  wire            mem_ready,
    output mem_req_t       mem_req,
    output logic           cpu_ready,
    output logic           tape_ready,
    output logic           cpu_hold,
    output logic           rom_loaded
);

    logic               loader_wr;
    logic               cpu_acc;
    logic               tape_acc;
    logic [`MEM_AW-1:0] loader_addr;
    mem_src_t           grant;
    mem_src_t           src_q;

    // Index 3 has no region
    assign loader_wr = ioctl.wr && (ioctl.index != 2'd3);

    // A requester still holds its request in its ready cycle, skip it once
    assign cpu_acc = (cpu.rd || cpu.wr) && (src_q != SRC_CPU);
    assign tape_acc = tape_req && (src_q != SRC_TAPE);

    always_comb begin
        case (ioctl.index)
            2'd0:    loader_addr = `MAINROM_BASE + `MEM_AW'(ioctl.addr[12:0]);
            2'd1:    loader_addr = `EXTROM_BASE + `MEM_AW'(ioctl.addr[13:0]);
            2'd2:    loader_addr = `TAPE_BASE + `MEM_AW'(ioctl.addr);
            default: loader_addr = '0;
        endcase
    end

    ////////////////////////////////
    // Priority select
    ////////////////////////////////

    always_comb begin
        mem_req = '0;
        grant   = SRC_NONE;
        if (loader_wr) begin
            grant         = SRC_LOADER;
            mem_req.addr  = loader_addr;
            mem_req.we    = 1'b1;
            mem_req.wdata = ioctl.dout;
        end else if (cpu_acc) begin
            grant         = SRC_CPU;
            mem_req.addr  = `MEM_AW'(cpu.addr);
            mem_req.rd    = cpu.rd;
            mem_req.we    = cpu.wr;
            mem_req.wdata = cpu.wdata;
        end else if (tape_acc) begin
            grant         = SRC_TAPE;
            mem_req.addr  = `TAPE_BASE + `MEM_AW'(tape_addr);
            mem_req.rd    = 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (cpu_reset) begin
            src_q <= SRC_NONE;
        end else begin
            src_q <= grant;
        end
    end

    // Ready goes back only to the owner of the request in flight
    assign cpu_ready = mem_ready && (src_q == SRC_CPU);
    assign tape_ready = mem_ready && (src_q == SRC_TAPE);

    ////////////////////////////////
    // Loader status
    ////////////////////////////////

    assign cpu_hold = ioctl.download && ((ioctl.index == 2'd0) || (ioctl.index == 2'd2));

    always_ff @(posedge clk_sys) begin
        if (cpu_reset) begin
            rom_loaded <= 1'b0;
        end else if (ioctl.download && (ioctl.index == 2'd1)) begin
            rom_loaded <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== mem_ram.sv ====
`include "aqr_macros.svh"

`default_nettype none

module mem_ram import aqr_pkg::*; (
    input  wire            clk_sys,
    input  wire            cpu_reset,
    input  wire mem_req_t  mem_req,
    output logic [7:0]     mem_rdata,
    output logic           mem_ready
);

    logic [7:0] mem [0:(1 << `MEM_AW) - 1];

    ////////////////////////////////
    // Storage
    ////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk_sys) begin
        if (mem_req.rd) begin
            mem_rdata <= mem[mem_req.addr];
        end
    end

    ////////////////////////////////
    // Handshake
    ////////////////////////////////

    // Every access is answered one cycle later, back to back allowed
    always_ff @(posedge clk_sys) begin
        if (cpu_reset) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= mem_req.rd | mem_req.we;
        end
    end

endmodule

`default_nettype wire

// ==== tape_clock.sv ====
`include "aqr_macros.svh"

`default_nettype none

module tape_clock (
    input  wire  clk_sys,
    input  wire  cpu_reset,
    input  wire  fast_tape,
    output logic ce_tape
);

    localparam int CW = $clog2(`TAPE_DIV);
    localparam logic [CW-1:0] LIM_NORMAL = CW'(`TAPE_DIV - 1);
    localparam logic [CW-1:0] LIM_FAST = CW'(`TAPE_DIV_FAST - 1);

    logic [CW-1:0] cnt;
    logic [CW-1:0] lim;
    logic          fast_q;

    // Mode sampled only at the wrap so a period is never cut short
    assign lim = fast_q ? LIM_FAST : LIM_NORMAL;

    always_ff @(posedge clk_sys) begin
        if (cpu_reset) begin
            cnt     <= '0;
            fast_q  <= 1'b0;
            ce_tape <= 1'b0;
        end else begin
            ce_tape <= 1'b0;
            if (cnt == lim) begin
                cnt     <= '0;
                fast_q  <= fast_tape;
                ce_tape <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tape_player.sv ====
`default_nettype none

module tape_player import aqr_pkg::*; (
    input  wire          clk_sys,
    input  wire          cpu_reset,
    input  wire          ce_tape,
    input  wire ioctl_t  ioctl,
    input  wire          tape_ready,
    input  wire [7:0]    mem_rdata,
    output logic         tape_req,
    output logic [15:0]  tape_addr,
    output logic         cass_out,
    output logic         tape_playing
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_PLAY,
        ST_DONE
    } state_t;

    state_t      state;
    logic        dl_q;
    logic        tape_dl;
    logic        dl_start;
    logic        dl_end;
    logic [16:0] tape_len;
    logic [16:0] wr_end;
    logic [16:0] byte_idx;
    logic [16:0] nxt_idx;
    logic [16:0] pf_idx;
    logic [7:0]  shift_q;
    logic [7:0]  buf_q;
    logic        buf_valid;
    logic [2:0]  bit_cnt;
    logic        byte_due;
    logic        load_first;
    logic        load_next;
    logic        shift_bit;
    logic        last_done;

    ////////////////////////////////
    // Download tracking
    ////////////////////////////////

    assign tape_dl = ioctl.download && (ioctl.index == 2'd2);
    assign dl_start = tape_dl && !dl_q;
    assign dl_end = dl_q && !ioctl.download && (ioctl.index == 2'd2);
    assign wr_end = {1'b0, ioctl.addr} + 17'd1;

    // Length is the highest written address plus one
    always_ff @(posedge clk_sys) begin
        if (cpu_reset) begin
            dl_q     <= 1'b0;
            tape_len <= '0;
        end else begin
            dl_q <= ioctl.download;
            if (dl_start) begin
                tape_len <= '0;
            end
            if (tape_dl && ioctl.wr && (dl_start || (wr_end > tape_len))) begin
                tape_len <= wr_end;
            end
        end
    end

    ////////////////////////////////
    // Playback strobes
    ////////////////////////////////

    assign nxt_idx = byte_idx + 17'd1;
    // Byte boundary on the strobe
    // A late prefetch leaves bit_cnt at 7 so the last bit stays on the line
    assign byte_due = ce_tape && (bit_cnt == 3'd7);

    assign load_first = (state == ST_FETCH) && ce_tape && buf_valid;
    assign load_next = (state == ST_PLAY) && byte_due && (nxt_idx != tape_len) && buf_valid;
    assign shift_bit = (state == ST_PLAY) && ce_tape && !byte_due;
    assign last_done = (state == ST_PLAY) && byte_due && (nxt_idx == tape_len);

    // Next byte to prefetch once a byte starts shifting
    assign pf_idx = load_first ? 17'd1 : nxt_idx + 17'd1;

    always_ff @(posedge clk_sys) begin
        if (tape_ready) begin
            buf_q <= mem_rdata;
        end
        if (load_first || load_next) begin
            shift_q <= buf_q;
        end else if (shift_bit) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    ////////////////////////////////
    // Control FSM
    ////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (cpu_reset) begin
            state        <= ST_IDLE;
            tape_req     <= 1'b0;
            tape_addr    <= '0;
            tape_playing <= 1'b0;
            cass_out     <= 1'b0;
            buf_valid    <= 1'b0;
            bit_cnt      <= '0;
            byte_idx     <= '0;
        end else begin
            // Fetch answered so the buffer is full
            if (tape_ready) begin
                tape_req  <= 1'b0;
                buf_valid <= 1'b1;
            end

            if ((state == ST_IDLE) || (state == ST_DONE)) begin
                if (dl_end && (tape_len != '0)) begin
                    state     <= ST_FETCH;
                    tape_req  <= 1'b1;
                    tape_addr <= '0;
                    buf_valid <= 1'b0;
                end else if (dl_start) begin
                    state <= ST_IDLE;
                end
            end

            if (load_first || load_next) begin
                state        <= ST_PLAY;
                tape_playing <= 1'b1;
                cass_out     <= buf_q[7];
                bit_cnt      <= '0;
                buf_valid    <= 1'b0;
                byte_idx     <= load_first ? 17'd0 : nxt_idx;
                if (pf_idx < tape_len) begin
                    tape_req  <= 1'b1;
                    tape_addr <= pf_idx[15:0];
                end
            end else if (shift_bit) begin
                bit_cnt  <= bit_cnt + 3'd1;
                cass_out <= shift_q[6];
            end else if (last_done) begin
                state        <= ST_DONE;
                tape_playing <= 1'b0;
                cass_out     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
